// ==== verilog/pet_spi_config.svh ====
//##########################################################
// Sizes and timing shared by the SPI memory bridge.
// Include this header in any file that needs a bus width,
// the memory depth or the SRAM wait state count.
//##########################################################

`ifndef PET_SPI_CONFIG_SVH
`define PET_SPI_CONFIG_SVH

// Address width for the full 128 KB space.
`define PET_ADDR_W 17

// Width of one memory word and of one SPI frame.
`define PET_DATA_W 8

// Number of bytes held by the SRAM target.
`define PET_MEM_DEPTH 131072

// Clock cycles from the first cycle of a request to ready.
// Must be at least 1.
`define PET_SRAM_WAIT 2

`endif

// ==== verilog/spi_cmd_pkg.sv ====
//##########################################################
// Types for the SPI side of the bridge: the decoded view of
// a received byte and the command sequencer states.
// Import into modules that decode SPI commands.
//##########################################################

`default_nettype none

package spi_cmd_pkg;

    // Command byte layout, MSB first on the wire.
    typedef struct packed {
        logic       rw_n;
        logic       set_addr;
        logic [4:0] rsvd;
        logic       a16;
    } spi_cmd_s;

    // One received frame, read as a raw byte or as a command.
    typedef union packed {
        logic [7:0] data;
        spi_cmd_s   cmd;
    } spi_cmd_u;

    // Sequencer states.
    // Bit 2 marks the transfer, bit 3 marks completion.
    typedef enum logic [3:0] {
        ST_READ_CMD     = 4'b0000,
        ST_READ_DATA    = 4'b0001,
        ST_READ_ADDR_HI = 4'b0010,
        ST_READ_ADDR_LO = 4'b0011,
        ST_XFER         = 4'b0100,
        ST_DONE         = 4'b1000
    } bridge_state_e;

endpackage

`default_nettype wire

// ==== verilog/mem_bus_pkg.sv ====
//##########################################################
// Request and response types of the internal memory bus.
// The bridge drives requests, the SRAM target answers.
//##########################################################

`default_nettype none

`include "pet_spi_config.svh"

package mem_bus_pkg;

    // Held stable while valid is high and ready is low.
    typedef struct packed {
        logic [`PET_ADDR_W-1:0] addr;
        logic [`PET_DATA_W-1:0] wdata;
        logic                   rw_n;
    } mem_req_s;

    // Read data is valid in the cycle ready is high.
    typedef struct packed {
        logic                   ready;
        logic [`PET_DATA_W-1:0] rdata;
    } mem_rsp_s;

endpackage

`default_nettype wire

// ==== verilog/spi_byte.sv ====
//##########################################################
// Byte-level SPI mode 0 receiver and transmitter.
// SCLK and MOSI are sampled in the system clock domain, so
// the SCLK half period must be at least six system cycles.
// Chip select high clears the bit counter and MISO.
//##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "pet_spi_config.svh"

module spi_byte (
    input  logic                   clk_sys_i,
    input  logic                   spi_cs_ni,
    input  logic                   spi_sclk_i,
    input  logic                   spi_rx_i,
    output logic                   spi_tx_o,
    output logic [`PET_DATA_W-1:0] rx_byte_o,
    output logic                   rx_valid_o,
    input  logic [`PET_DATA_W-1:0] tx_byte_i
);
    localparam int CNT_W = $clog2(`PET_DATA_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`PET_DATA_W - 1);

    logic [2:0]             sclk_q;
    logic [1:0]             mosi_q;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic [CNT_W-1:0]       bit_cnt;
    logic [`PET_DATA_W-1:0] rx_shift;
    logic [`PET_DATA_W-1:0] tx_shift;

    // Two synchronizer stages plus one stage for edge detection.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            sclk_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_sclk_i};
        end
    end

    // MOSI takes the same two stages so it lines up with SCLK.
    always_ff @(posedge clk_sys_i) begin
        mosi_q <= {mosi_q[0], spi_rx_i};
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];

    // Count bits on rising edges and flag the eighth one.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (sclk_rise) begin
                rx_valid_o <= (bit_cnt == LAST_BIT);
                bit_cnt    <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
            end
        end
    end

    // Receive shift register, MSB first.
    always_ff @(posedge clk_sys_i) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[`PET_DATA_W-2:0], mosi_q[1]};
        end
    end

    assign rx_byte_o = rx_shift;

    // A falling edge with the counter at zero follows a completed byte.
    // Load the next byte there, otherwise shift.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            tx_shift <= '0;
        end else if (sclk_fall) begin
            if (bit_cnt == '0) begin
                tx_shift <= tx_byte_i;
            end else begin
                tx_shift <= {tx_shift[`PET_DATA_W-2:0], 1'b0};
            end
        end
    end

    assign spi_tx_o = tx_shift[`PET_DATA_W-1];

    // Byte strobe is a single-cycle pulse.
    a_rx_valid_pulse: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
        rx_valid_o |=> !rx_valid_o
    );

endmodule

`default_nettype wire

// ==== verilog/spi_bridge.sv ====
//##########################################################
// SPI command sequencer.
// Decodes a command byte and its optional data and address
// bytes, then issues one memory transfer per chip select.
// The address persists across selects and auto-increments.
//##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "pet_spi_config.svh"

module spi_bridge
    import spi_cmd_pkg::*, mem_bus_pkg::*;
(
    input  logic                   clk_sys_i,
    input  logic                   spi_cs_ni,
    input  spi_cmd_u               rx_byte_i,
    input  logic                   rx_valid_i,
    output logic [`PET_DATA_W-1:0] tx_byte_o,
    output mem_req_s               mem_req_o,
    output logic                   mem_valid_o,
    input  mem_rsp_s               mem_rsp_i
);
    bridge_state_e          state;
    logic                   cmd_rw_n;
    logic                   cmd_set_addr;
    logic [`PET_ADDR_W-1:0] addr_q;
    logic [`PET_DATA_W-1:0] wdata_q;

    // Control path, cleared whenever chip select goes high.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            state        <= ST_READ_CMD;
            cmd_rw_n     <= 1'b1;
            cmd_set_addr <= 1'b0;
        end else begin
            unique case (state)
                ST_READ_CMD: begin
                    if (rx_valid_i) begin
                        cmd_rw_n     <= rx_byte_i.cmd.rw_n;
                        cmd_set_addr <= rx_byte_i.cmd.set_addr;
                        if (!rx_byte_i.cmd.rw_n) begin
                            state <= ST_READ_DATA;
                        end else if (rx_byte_i.cmd.set_addr) begin
                            state <= ST_READ_ADDR_HI;
                        end else begin
                            state <= ST_XFER;
                        end
                    end
                end
                ST_READ_DATA: begin
                    if (rx_valid_i) begin
                        state <= cmd_set_addr ? ST_READ_ADDR_HI : ST_XFER;
                    end
                end
                ST_READ_ADDR_HI: begin
                    if (rx_valid_i) begin
                        state <= ST_READ_ADDR_LO;
                    end
                end
                ST_READ_ADDR_LO: begin
                    if (rx_valid_i) begin
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (mem_rsp_i.ready) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // Wait here for chip select to rise.
                end
                default: state <= ST_READ_CMD;
            endcase
        end
    end

    // Address, write data and read data survive across selects.
    always_ff @(posedge clk_sys_i) begin
        case (state)
            ST_READ_CMD: begin
                if (rx_valid_i && rx_byte_i.cmd.set_addr) begin
                    addr_q[`PET_ADDR_W-1] <= rx_byte_i.cmd.a16;
                end
            end
            ST_READ_DATA: begin
                if (rx_valid_i) begin
                    wdata_q <= rx_byte_i.data;
                end
            end
            ST_READ_ADDR_HI: begin
                if (rx_valid_i) begin
                    addr_q[15:8] <= rx_byte_i.data;
                end
            end
            ST_READ_ADDR_LO: begin
                if (rx_valid_i) begin
                    addr_q[7:0] <= rx_byte_i.data;
                end
            end
            ST_XFER: begin
                if (mem_rsp_i.ready) begin
                    addr_q <= addr_q + 1'b1;
                    if (cmd_rw_n) begin
                        tx_byte_o <= mem_rsp_i.rdata;
                    end
                end
            end
            default: ;
        endcase
    end

    assign mem_valid_o = (state == ST_XFER);
    assign mem_req_o   = '{addr: addr_q, wdata: wdata_q, rw_n: cmd_rw_n};

    // The request may not move until the target accepts it.
    a_req_stable: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
        mem_valid_o && !mem_rsp_i.ready |=> $stable(mem_req_o)
    );

    // One transfer per select.
    a_one_xfer: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
        mem_valid_o && mem_rsp_i.ready |=> state == ST_DONE && !mem_valid_o
    );

endmodule

`default_nettype wire

// ==== verilog/sram_target.sv ====
//##########################################################
// Byte-wide synchronous SRAM model for the memory bus.
// Ready rises PET_SRAM_WAIT cycles after valid, for one
// cycle, and the access takes place on that cycle.
//##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "pet_spi_config.svh"

module sram_target
    import mem_bus_pkg::*;
(
    input  logic     clk_sys_i,
    input  logic     spi_cs_ni,
    input  mem_req_s mem_req_i,
    input  logic     mem_valid_i,
    output mem_rsp_s mem_rsp_o
);
    localparam int WAIT_W = $clog2(`PET_SRAM_WAIT + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`PET_SRAM_WAIT - 1);
    localparam logic [WAIT_W-1:0] WAIT_END  = WAIT_W'(`PET_SRAM_WAIT);

    logic [`PET_DATA_W-1:0] mem [`PET_MEM_DEPTH];
    logic [WAIT_W-1:0]      wait_cnt;
    logic                   access;
    logic                   rsp_ready;
    logic [`PET_DATA_W-1:0] rsp_rdata;

    assign access = mem_valid_i && (wait_cnt == WAIT_LAST);

    // Counter saturates at the end so ready fires only once.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            wait_cnt  <= '0;
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= access;
            if (!mem_valid_i) begin
                wait_cnt <= '0;
            end else if (wait_cnt != WAIT_END) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Storage access.
    always_ff @(posedge clk_sys_i) begin
        if (access) begin
            if (mem_req_i.rw_n) begin
                rsp_rdata <= mem[mem_req_i.addr];
            end else begin
                mem[mem_req_i.addr] <= mem_req_i.wdata;
            end
        end
    end

    assign mem_rsp_o = '{ready: rsp_ready, rdata: rsp_rdata};

    // Ready must never arrive for a request the bridge has dropped.
    a_ready_in_valid: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
        mem_rsp_o.ready |-> mem_valid_i
    );

endmodule

`default_nettype wire

// ==== verilog/spi_mem_top.sv ====
//##########################################################
// SPI-to-memory bridge top level.
// Connects the SPI pins to the byte engine, the command
// sequencer and the SRAM target. MISO is a plain output.
//##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "pet_spi_config.svh"

module spi_mem_top
    import spi_cmd_pkg::*, mem_bus_pkg::*;
(
    input  logic clk_sys_i,
    input  logic spi_cs_ni,
    input  logic spi_sclk_i,
    input  logic spi_rx_i,
    output logic spi_tx_o
);
    spi_cmd_u               rx_byte;
    logic                   rx_valid;
    logic [`PET_DATA_W-1:0] tx_byte;
    mem_req_s               mem_req;
    logic                   mem_valid;
    mem_rsp_s               mem_rsp;

    spi_byte u_spi_byte (
        .clk_sys_i  (clk_sys_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_sclk_i (spi_sclk_i),
        .spi_rx_i   (spi_rx_i),
        .spi_tx_o   (spi_tx_o),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid),
        .tx_byte_i  (tx_byte)
    );

    spi_bridge u_spi_bridge (
        .clk_sys_i   (clk_sys_i),
        .spi_cs_ni   (spi_cs_ni),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .tx_byte_o   (tx_byte),
        .mem_req_o   (mem_req),
        .mem_valid_o (mem_valid),
        .mem_rsp_i   (mem_rsp)
    );

    sram_target u_sram_target (
        .clk_sys_i   (clk_sys_i),
        .spi_cs_ni   (spi_cs_ni),
        .mem_req_i   (mem_req),
        .mem_valid_i (mem_valid),
        .mem_rsp_o   (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== verification/tb_spi_host.svh ====
//############################################################
// SPI mode 0 host tasks, included inside the testbench.
// SCLK runs with a half period of HALF_SCLK system cycles,
// and every pin changes DRIVE_DELAY ns after a clock edge.
//############################################################

`ifndef TB_SPI_HOST_SVH
`define TB_SPI_HOST_SVH

logic [7:0] frame_buf [6];
int         frame_cnt;

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #DRIVE_DELAY;
endtask

// MOSI is set while SCLK is low, MISO is taken just before the rising edge.
task automatic spi_shift(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    int i;
    rx = '0;
    for (i = 0; i < nbits; i++) begin
        spi_mosi = tx[7 - i];
        wait_cycles(HALF_SCLK);
        rx[7 - i] = spi_miso;
        spi_sclk  = 1'b1;
        wait_cycles(HALF_SCLK);
        spi_sclk  = 1'b0;
    end
endtask

task automatic wait_miso_low();
    int cnt;
    cnt = 0;
    while (spi_miso !== 1'b0 && cnt < 4) begin
        wait_cycles(1);
        cnt++;
    end
    if (spi_miso !== 1'b0) begin
        fail_run("MISO did not return low after chip select rose.");
    end
endtask

task automatic begin_select();
    spi_cs_n = 1'b0;
    wait_cycles(4);
endtask

task automatic end_select();
    wait_cycles(HALF_SCLK);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    wait_miso_low();
    wait_cycles(4);
endtask

// Command byte is rw_n, set_addr, five zero bits, then address bit 16.
task automatic build_frames(input logic rw_n, input logic set_addr,
                            input logic [16:0] addr, input logic [7:0] wdata);
    frame_buf[0] = {rw_n, set_addr, 5'b00000, addr[16]};
    frame_cnt    = 1;
    if (!rw_n) begin
        frame_buf[frame_cnt] = wdata;
        frame_cnt            = frame_cnt + 1;
    end
    if (set_addr) begin
        frame_buf[frame_cnt]     = addr[15:8];
        frame_buf[frame_cnt + 1] = addr[7:0];
        frame_cnt                = frame_cnt + 2;
    end
    // Trailing frame that carries the read data back.
    frame_buf[frame_cnt] = 8'h00;
    frame_cnt            = frame_cnt + 1;
endtask

task automatic spi_command(input logic rw_n, input logic set_addr,
                           input logic [16:0] addr, input logic [7:0] wdata,
                           output logic [7:0] miso_byte);
    logic [7:0] discard;
    int         i;
    build_frames(rw_n, set_addr, addr, wdata);
    begin_select();
    for (i = 0; i < frame_cnt - 1; i++) begin
        spi_shift(frame_buf[i], 8, discard);
    end
    spi_shift(frame_buf[frame_cnt - 1], 8, miso_byte);
    end_select();
endtask

task automatic spi_abort(input logic rw_n, input logic set_addr,
                         input logic [16:0] addr, input logic [7:0] wdata,
                         input int full_frames, input int extra_bits);
    logic [7:0] discard;
    int         i;
    build_frames(rw_n, set_addr, addr, wdata);
    begin_select();
    for (i = 0; i < full_frames; i++) begin
        spi_shift(frame_buf[i], 8, discard);
    end
    spi_shift(frame_buf[full_frames], extra_bits, discard);
    end_select();
endtask

`endif

// ==== verification/tb_spi_mem.sv ====
//############################################################
// Self-checking testbench for the SPI memory bridge.
// Sends SPI mode 0 commands to the top level, mirrors the
// memory and the address pointer in a reference model, and
// compares every byte read back on MISO.
//############################################################

`timescale 1ns/10ps
`default_nettype none

`include "pet_spi_config.svh"

module tb_spi_mem ();
    localparam int HALF_SCLK   = 8;
    localparam int DRIVE_DELAY = 2;
    localparam int RANDOM_OPS  = 200;
    localparam int WIN_SIZE    = 64;
    // Window straddles the boundary between the two 64 KB halves.
    localparam logic [`PET_ADDR_W-1:0] WIN_BASE = 17'h0_ffe0;

    logic clk_sys = 1'b0;
    logic spi_cs_n;
    logic spi_sclk;
    logic spi_mosi;
    logic spi_miso;

    // Reference model state.
    logic [`PET_DATA_W-1:0] ref_mem [`PET_MEM_DEPTH];
    bit                     known [`PET_MEM_DEPTH];
    logic [`PET_ADDR_W-1:0] ptr;
    logic [`PET_DATA_W-1:0] got_q [$];
    logic [`PET_DATA_W-1:0] exp_q [$];
    logic [`PET_DATA_W-1:0] cmp_got;
    logic [`PET_DATA_W-1:0] cmp_exp;

    always #10 clk_sys = ~clk_sys;

    spi_mem_top u_spi_mem_top (
        .clk_sys_i  (clk_sys),
        .spi_cs_ni  (spi_cs_n),
        .spi_sclk_i (spi_sclk),
        .spi_rx_i   (spi_mosi),
        .spi_tx_o   (spi_miso)
    );

    task automatic fail_run(input string reason);
        $display("ERROR: %s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped after an error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch.");
        end
    endtask

    `include "tb_spi_host.svh"

    // A command uses its own address bytes, or else the running pointer.
    function automatic logic [`PET_ADDR_W-1:0] access_addr(
        input logic                   set_addr,
        input logic [`PET_ADDR_W-1:0] addr
    );
        return set_addr ? addr : ptr;
    endfunction

    function automatic logic [`PET_DATA_W-1:0] expected_read(
        input logic                   set_addr,
        input logic [`PET_ADDR_W-1:0] addr
    );
        return ref_mem[access_addr(set_addr, addr)];
    endfunction

    task automatic run_command(input logic rw_n, input logic set_addr,
                               input logic [`PET_ADDR_W-1:0] addr,
                               input logic [`PET_DATA_W-1:0] wdata);
        logic [`PET_ADDR_W-1:0] target;
        logic [`PET_DATA_W-1:0] expected;
        logic [`PET_DATA_W-1:0] miso_byte;
        target   = access_addr(set_addr, addr);
        expected = expected_read(set_addr, addr);
        spi_command(rw_n, set_addr, addr, wdata, miso_byte);
        if (rw_n) begin
            got_q.push_back(miso_byte);
            exp_q.push_back(expected);
        end else begin
            ref_mem[target] = wdata;
            known[target]   = 1'b1;
        end
        // Each completed transfer moves the pointer one byte on.
        ptr = target + `PET_ADDR_W'(1);
    endtask

    // Comparison process.
    always @(posedge clk_sys) begin
        if (got_q.size() > 0) begin
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            check_value("spi_miso", 32'(cmp_got), 32'(cmp_exp));
        end
    end

    task automatic wait_compare_idle();
        int cnt;
        cnt = 0;
        while (got_q.size() != 0 && cnt < 16) begin
            wait_cycles(1);
            cnt++;
        end
        if (got_q.size() != 0) begin
            fail_run("Timed out waiting for the read comparisons to finish.");
        end
    endtask

    initial begin
        logic [`PET_ADDR_W-1:0] a;
        logic [`PET_DATA_W-1:0] d;
        logic                   rw_n;
        logic                   set_addr;
        int                     i;
        void'($urandom(32'hdfb6_1d30));
        spi_cs_n = 1'b1;
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        ptr      = 'x;
        wait_cycles(4);
        check_value("spi_miso", 32'(spi_miso), 32'd0);
        check_value("mem_valid", 32'(u_spi_mem_top.mem_valid), 32'd0);
        check_value("mem_ready", 32'(u_spi_mem_top.u_sram_target.rsp_ready), 32'd0);

        // Addressed write, then addressed read of the same byte.
        a = 17'($urandom);
        d = 8'($urandom);
        run_command(1'b0, 1'b1, a, d);
        run_command(1'b1, 1'b1, a, 8'h00);

        // Sequential writes through auto-increment, read back both ways.
        a = 17'($urandom);
        d = 8'($urandom);
        for (i = 0; i < 4; i++) begin
            run_command(1'b0, i == 0, a, d + 8'(i));
        end
        run_command(1'b1, 1'b1, a + `PET_ADDR_W'(1), 8'h00);
        for (i = 0; i < 4; i++) begin
            run_command(1'b1, i == 0, a, 8'h00);
        end

        // Same low 16 bits in both halves.
        a = {1'b0, 16'($urandom)};
        d = 8'($urandom);
        run_command(1'b0, 1'b1, a, d);
        run_command(1'b0, 1'b1, {1'b1, a[15:0]}, ~d);
        run_command(1'b1, 1'b1, a, 8'h00);
        run_command(1'b1, 1'b1, {1'b1, a[15:0]}, 8'h00);

        // Random mix, reads only where the model knows the contents.
        for (i = 0; i < RANDOM_OPS; i++) begin
            rw_n     = 1'($urandom_range(1));
            set_addr = ($urandom_range(2) != 0);
            a        = WIN_BASE + 17'($urandom_range(WIN_SIZE - 1));
            d        = 8'($urandom);
            if (rw_n && !known[access_addr(set_addr, a)]) begin
                rw_n = 1'b0;
            end
            run_command(rw_n, set_addr, a, d);
        end

        // Chip select rising mid-command must leave memory untouched.
        a = 17'($urandom);
        d = 8'($urandom);
        run_command(1'b0, 1'b1, a, d);
        spi_abort(1'b0, 1'b1, a, ~d, 3, 4);
        // An aborted command may leave a partial address behind.
        ptr = 'x;
        run_command(1'b1, 1'b1, a, 8'h00);
        spi_abort(1'b1, 1'b1, a, 8'h00, 1, 5);
        ptr = 'x;
        run_command(1'b0, 1'b1, a + `PET_ADDR_W'(1), ~d);
        run_command(1'b1, 1'b1, a, 8'h00);
        run_command(1'b1, 1'b0, a, 8'h00);

        wait_compare_idle();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
+incdir+verification
verilog/spi_cmd_pkg.sv
verilog/mem_bus_pkg.sv
verilog/spi_byte.sv
verilog/spi_bridge.sv
verilog/sram_target.sv
verilog/spi_mem_top.sv
verification/tb_spi_mem.sv

// ==== Makefile ====
TOP = tb_spi_mem
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
